/* Bender.yml */
package:
  name: aes_cipher_ctrl

sources:
  - hdl/aes_ctrl_pkg.sv
  - hdl/aes_ctrl_sp2v_chk.sv
  - hdl/aes_ctrl_fsm.sv
  - hdl/aes_ctrl_rail_combine.sv
  - hdl/aes_cipher_ctrl.sv
  - target: test
    files:
      - tb/aes_cipher_ctrl_sva.sv
      - tb/aes_cipher_ctrl_tb.sv

/* build.f */
hdl/aes_ctrl_pkg.sv
hdl/aes_ctrl_sp2v_chk.sv
hdl/aes_ctrl_fsm.sv
hdl/aes_ctrl_rail_combine.sv
hdl/aes_cipher_ctrl.sv
tb/aes_cipher_ctrl_sva.sv
tb/aes_cipher_ctrl_tb.sv

/* hdl/aes_cipher_ctrl.sv */
// AES cipher control top with redundant rail FSMs, encoding check and shared flag registers
`default_nettype none
`timescale 1ns/1ps

module aes_cipher_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  aes_ctrl_pkg::ciph_cfg_t cfg_i,     // Sampled at accept
  input  aes_ctrl_pkg::sp2v_e     in_valid_i,
  output aes_ctrl_pkg::sp2v_e     in_ready_o,
  output aes_ctrl_pkg::sp2v_e     out_valid_o,
  input  aes_ctrl_pkg::sp2v_e     out_ready_i,

  input  logic                    key_clear_i,
  input  logic                    op_err_i,
  input  logic                    alert_fatal_i,

  output aes_ctrl_pkg::sp2v_e     state_we_o,
  output aes_ctrl_pkg::dp_ctrl_t  dp_ctrl_o,
  output aes_ctrl_pkg::ciph_op_e  key_expand_op_o,
  output logic                    key_clear_o,
  output logic                    alert_o
);

  localparam int NumChkSig = 3;

  aes_ctrl_pkg::sp2v_e [NumChkSig-1:0]                    chk_sig;
  logic [NumChkSig-1:0][aes_ctrl_pkg::Sp2vWidth-1:0]      chk_raw;
  logic                                                   enc_err;
  logic                                                   rail_err;
  logic                                                   fault;

  // Multi-rail outputs
  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                     mr_in_ready;
  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                     mr_out_valid;
  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                     mr_state_we;
  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                     mr_alert;
  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                     mr_clear_done;
  aes_ctrl_pkg::dp_ctrl_t [aes_ctrl_pkg::Sp2vWidth-1:0]   mr_dp_ctrl;

  aes_ctrl_pkg::sp2v_e     state_we_q;
  logic                    clear_done;
  logic                    key_clear_d, key_clear_q;
  logic                    idle;
  logic                    accept;
  aes_ctrl_pkg::ciph_op_e  op_q;

  //////////////////////////////
  // Encoding check
  //////////////////////////////

  assign chk_sig[0] = in_valid_i;
  assign chk_sig[1] = out_ready_i;
  assign chk_sig[2] = state_we_q; // Write enable feedback

  aes_ctrl_sp2v_chk #(
    .NumSig ( NumChkSig )
  ) aes_ctrl_sp2v_chk_i (
    .sig_i ( chk_sig ),
    .sig_o ( chk_raw ),
    .err_o ( enc_err )
  );

  assign fault = enc_err | rail_err | op_err_i | alert_fatal_i;

  //////////////////////////////
  // Rails
  //////////////////////////////

  for (genvar i = 0; i < aes_ctrl_pkg::Sp2vWidth; i++) begin : gen_rail
    aes_ctrl_fsm #(
      .RailActiveLow ( aes_ctrl_pkg::Sp2vLogicHigh[i] == 1'b0 )
    ) aes_ctrl_fsm_i (
      .clk_i            ( clk_i            ),
      .rst_ni           ( rst_ni           ),
      .in_valid_i       ( chk_raw[0][i]    ),
      .in_ready_o       ( mr_in_ready[i]   ),
      .out_valid_o      ( mr_out_valid[i]  ),
      .out_ready_i      ( chk_raw[1][i]    ),
      .cfg_i            ( cfg_i            ),
      .key_clear_i      ( key_clear_i      ),
      .key_clear_q_i    ( key_clear_q      ),
      .fault_i          ( fault            ),
      .state_we_o       ( mr_state_we[i]   ),
      .dp_ctrl_o        ( mr_dp_ctrl[i]    ),
      .key_clear_done_o ( mr_clear_done[i] ),
      .alert_o          ( mr_alert[i]      )
    );
  end

  aes_ctrl_rail_combine aes_ctrl_rail_combine_i (
    .in_ready_i       ( mr_in_ready   ),
    .out_valid_i      ( mr_out_valid  ),
    .state_we_i       ( mr_state_we   ),
    .dp_ctrl_i        ( mr_dp_ctrl    ),
    .alert_i          ( mr_alert      ),
    .key_clear_done_i ( mr_clear_done ),
    .in_ready_o       ( in_ready_o    ),
    .out_valid_o      ( out_valid_o   ),
    .state_we_o       ( state_we_o    ),
    .dp_ctrl_o        ( dp_ctrl_o     ),
    .alert_o          ( alert_o       ),
    .key_clear_done_o ( clear_done    ),
    .rail_err_o       ( rail_err      )
  );

  //////////////////////////////
  // Shared registers
  //////////////////////////////

  assign idle   = (in_ready_o == aes_ctrl_pkg::SP2V_HIGH) & ~fault;
  assign accept = idle & ~key_clear_i & (in_valid_i == aes_ctrl_pkg::SP2V_HIGH);

  // Set on entry to the clear state, dropped once every rail reports done
  assign key_clear_d = (idle & key_clear_i) | (key_clear_q & ~clear_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin : shared_reg
    if (!rst_ni) begin
      state_we_q  <= aes_ctrl_pkg::SP2V_LOW;
      key_clear_q <= 1'b0;
      op_q        <= aes_ctrl_pkg::CIPH_FWD;
    end else begin
      state_we_q  <= state_we_o;
      key_clear_q <= key_clear_d;
      if (accept) begin
        op_q <= cfg_i.op;
      end
    end
  end

  assign key_expand_op_o = op_q;
  assign key_clear_o     = key_clear_q;

endmodule

`default_nettype wire

/* hdl/aes_ctrl_fsm.sv */
// Single rail of the AES cipher control FSM with round counter, positive or inverted polarity
`default_nettype none
`timescale 1ns/1ps

module aes_ctrl_fsm #(
  parameter bit RailActiveLow = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Handshake bits in rail polarity
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,

  input  aes_ctrl_pkg::ciph_cfg_t cfg_i,
  input  logic                  key_clear_i,
  input  logic                  key_clear_q_i,
  input  logic                  fault_i,

  // Datapath control
  output logic                  state_we_o,  // Rail polarity
  output aes_ctrl_pkg::dp_ctrl_t dp_ctrl_o,
  output logic                  key_clear_done_o,
  output logic                  alert_o
);

  aes_ctrl_pkg::ctrl_state_e              state_d, state_q;
  logic [aes_ctrl_pkg::RoundWidth-1:0]    rnd_d, rnd_q;
  aes_ctrl_pkg::key_len_e                 key_len_d, key_len_q;
  logic [aes_ctrl_pkg::RoundWidth-1:0]    nr;
  logic [aes_ctrl_pkg::RoundWidth-1:0]    last_mid_rnd;

  // Positive-logic views of the rail bits
  logic in_valid;
  logic out_ready;
  logic in_ready;
  logic out_valid;
  logic state_we;

  //////////////////////////////
  // Polarity boundary
  //////////////////////////////

  assign in_valid  = in_valid_i ^ RailActiveLow;
  assign out_ready = out_ready_i ^ RailActiveLow;

  assign in_ready_o  = in_ready ^ RailActiveLow;
  assign out_valid_o = out_valid ^ RailActiveLow;
  assign state_we_o  = state_we ^ RailActiveLow;

  //////////////////////////////
  // Next state
  //////////////////////////////

  assign nr           = aes_ctrl_pkg::num_rounds(key_len_q);
  assign last_mid_rnd = nr - 4'd1;

  always_comb begin : fsm_comb
    state_d   = state_q;
    rnd_d     = rnd_q;
    key_len_d = key_len_q;

    unique case (state_q)
      aes_ctrl_pkg::CTRL_IDLE: begin
        // Key clear wins over a new job
        if (key_clear_i) begin
          state_d = aes_ctrl_pkg::CTRL_CLEAR;
        end else if (in_valid) begin
          state_d   = aes_ctrl_pkg::CTRL_INIT;
          rnd_d     = '0;
          key_len_d = cfg_i.key_len;
        end
      end

      aes_ctrl_pkg::CTRL_INIT: begin
        state_d = aes_ctrl_pkg::CTRL_ROUND;
        rnd_d   = 4'd1;
      end

      aes_ctrl_pkg::CTRL_ROUND: begin
        rnd_d = rnd_q + 4'd1;
        if (rnd_q == last_mid_rnd) begin
          state_d = aes_ctrl_pkg::CTRL_FINAL;
        end
      end

      aes_ctrl_pkg::CTRL_FINAL: state_d = aes_ctrl_pkg::CTRL_DONE;

      aes_ctrl_pkg::CTRL_DONE: begin
        if (out_ready) begin // Result taken
          state_d = aes_ctrl_pkg::CTRL_IDLE;
          rnd_d   = '0;
        end
      end

      aes_ctrl_pkg::CTRL_CLEAR: state_d = aes_ctrl_pkg::CTRL_IDLE;

      aes_ctrl_pkg::CTRL_ERROR: state_d = aes_ctrl_pkg::CTRL_ERROR; // Terminal

      default: state_d = aes_ctrl_pkg::CTRL_ERROR;
    endcase

    // Any fault overrides the regular sequence
    if (fault_i) begin
      state_d = aes_ctrl_pkg::CTRL_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      state_q   <= aes_ctrl_pkg::CTRL_IDLE;
      rnd_q     <= '0;
      key_len_q <= aes_ctrl_pkg::AES_128;
    end else begin
      state_q   <= state_d;
      rnd_q     <= rnd_d;
      key_len_q <= key_len_d;
    end
  end

  //////////////////////////////
  // Moore outputs
  //////////////////////////////

  assign in_ready  = (state_q == aes_ctrl_pkg::CTRL_IDLE);
  assign out_valid = (state_q == aes_ctrl_pkg::CTRL_DONE);
  assign state_we  = (state_q == aes_ctrl_pkg::CTRL_INIT)  ||
                     (state_q == aes_ctrl_pkg::CTRL_ROUND) ||
                     (state_q == aes_ctrl_pkg::CTRL_FINAL);
  assign alert_o   = (state_q == aes_ctrl_pkg::CTRL_ERROR);

  // Back in idle after a clear cycle
  assign key_clear_done_o = (state_q == aes_ctrl_pkg::CTRL_IDLE) & key_clear_q_i;

  always_comb begin : dp_ctrl_decode
    dp_ctrl_o.round = rnd_q;
    unique case (state_q)
      aes_ctrl_pkg::CTRL_ROUND: begin
        dp_ctrl_o.state_sel  = aes_ctrl_pkg::STATE_ROUND;
        dp_ctrl_o.add_rk_sel = aes_ctrl_pkg::ADD_RK_ROUND;
      end
      // Final selectors are held while the result waits
      aes_ctrl_pkg::CTRL_FINAL,
      aes_ctrl_pkg::CTRL_DONE: begin
        dp_ctrl_o.state_sel  = aes_ctrl_pkg::STATE_ROUND;
        dp_ctrl_o.add_rk_sel = aes_ctrl_pkg::ADD_RK_FINAL;
      end
      default: begin
        dp_ctrl_o.state_sel  = aes_ctrl_pkg::STATE_INIT;
        dp_ctrl_o.add_rk_sel = aes_ctrl_pkg::ADD_RK_INIT;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/aes_ctrl_pkg.sv */
// AES cipher control package with sparse encodings, state enums and datapath control types
`default_nettype none

package aes_ctrl_pkg;

  //////////////////////////////
  // Sparse encoding
  //////////////////////////////

  parameter int Sp2vWidth = 2; // One rail per bit

  typedef enum logic [Sp2vWidth-1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  // Rail i is positive when bit i of SP2V_HIGH is set
  parameter logic [Sp2vWidth-1:0] Sp2vLogicHigh = 2'b01;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  typedef struct packed {
    ciph_op_e op;
    key_len_e key_len;
  } ciph_cfg_t;

  //////////////////////////////
  // Rail FSM and datapath
  //////////////////////////////

  typedef enum logic [2:0] {
    CTRL_IDLE  = 3'b000,
    CTRL_INIT  = 3'b001,
    CTRL_ROUND = 3'b010,
    CTRL_FINAL = 3'b011,
    CTRL_DONE  = 3'b100,
    CTRL_CLEAR = 3'b101,
    CTRL_ERROR = 3'b110
  } ctrl_state_e;

  typedef enum logic [1:0] {
    STATE_INIT  = 2'b01, // Load input block
    STATE_ROUND = 2'b10  // Take round output
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  parameter int RoundWidth = 4;

  typedef struct packed {
    state_sel_e            state_sel;
    add_rk_sel_e           add_rk_sel;
    logic [RoundWidth-1:0] round;
  } dp_ctrl_t;

  // Number of rounds Nr for a given key length
  function automatic logic [RoundWidth-1:0] num_rounds(key_len_e key_len);
    logic [RoundWidth-1:0] nr;
    unique case (key_len)
      AES_192: nr = 4'd12;
      AES_256: nr = 4'd14;
      default: nr = 4'd10;
    endcase
    return nr;
  endfunction

endpackage

`default_nettype wire

/* hdl/aes_ctrl_rail_combine.sv */
// Rail combiner merging per-rail FSM outputs and detecting disagreement between rails
`default_nettype none
`timescale 1ns/1ps

module aes_ctrl_rail_combine (
  // Per-rail sparse bits
  input  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                   in_ready_i,
  input  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                   out_valid_i,
  input  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                   state_we_i,

  // Per-rail flags and selectors
  input  aes_ctrl_pkg::dp_ctrl_t [aes_ctrl_pkg::Sp2vWidth-1:0] dp_ctrl_i,
  input  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                   alert_i,
  input  logic [aes_ctrl_pkg::Sp2vWidth-1:0]                   key_clear_done_i,

  output aes_ctrl_pkg::sp2v_e                                  in_ready_o,
  output aes_ctrl_pkg::sp2v_e                                  out_valid_o,
  output aes_ctrl_pkg::sp2v_e                                  state_we_o,
  output aes_ctrl_pkg::dp_ctrl_t                               dp_ctrl_o,
  output logic                                                 alert_o,
  output logic                                                 key_clear_done_o,
  output logic                                                 rail_err_o
);

  logic [$bits(aes_ctrl_pkg::dp_ctrl_t)-1:0] dp_ctrl_or;

  //////////////////////////////
  // Sparse outputs
  //////////////////////////////

  // Each rail owns one bit of the code
  assign in_ready_o  = aes_ctrl_pkg::sp2v_e'(in_ready_i);
  assign out_valid_o = aes_ctrl_pkg::sp2v_e'(out_valid_i);
  assign state_we_o  = aes_ctrl_pkg::sp2v_e'(state_we_i);

  //////////////////////////////
  // Flags
  //////////////////////////////

  assign alert_o          = |alert_i;          // One rail is enough to alert
  assign key_clear_done_o = &key_clear_done_i; // All rails must agree

  //////////////////////////////
  // Selectors and round
  //////////////////////////////

  always_comb begin : merge_dp_ctrl
    dp_ctrl_or = '0;
    for (int i = 0; i < aes_ctrl_pkg::Sp2vWidth; i++) begin
      dp_ctrl_or = dp_ctrl_or | dp_ctrl_i[i];
    end
  end

  assign dp_ctrl_o = aes_ctrl_pkg::dp_ctrl_t'(dp_ctrl_or);

  // A rail differing from the merged value means the rails diverged
  always_comb begin : cmp_rails
    rail_err_o = 1'b0;
    for (int i = 0; i < aes_ctrl_pkg::Sp2vWidth; i++) begin
      if (dp_ctrl_i[i] != dp_ctrl_o) begin
        rail_err_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/aes_ctrl_sp2v_chk.sv */
// Sparse encoding checker passing sp2v signals through and flagging invalid codes
`default_nettype none
`timescale 1ns/1ps

module aes_ctrl_sp2v_chk #(
  parameter int NumSig = 3
) (
  input  aes_ctrl_pkg::sp2v_e [NumSig-1:0]                          sig_i,
  output logic [NumSig-1:0][aes_ctrl_pkg::Sp2vWidth-1:0]            sig_o,
  output logic                                                      err_o
);

  logic [NumSig-1:0] sig_err;

  //////////////////////////////
  // Per-signal check
  //////////////////////////////

  for (genvar i = 0; i < NumSig; i++) begin : gen_chk
    // Raw bits so each rail picks its own
    assign sig_o[i] = sig_i[i];

    // 00 and 11 are not valid codes
    assign sig_err[i] = !((sig_i[i] == aes_ctrl_pkg::SP2V_HIGH) ||
                          (sig_i[i] == aes_ctrl_pkg::SP2V_LOW));
  end

  assign err_o = |sig_err;

endmodule

`default_nettype wire

/* tb/aes_cipher_ctrl_sva.sv */
// Bound assertions on alert stickiness, sparse encodings and handshake stability of the cipher control
`default_nettype none
`timescale 1ns/1ps

module aes_cipher_ctrl_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input aes_ctrl_pkg::sp2v_e in_ready_o,
  input aes_ctrl_pkg::sp2v_e out_valid_o,
  input aes_ctrl_pkg::sp2v_e out_ready_i,
  input aes_ctrl_pkg::sp2v_e state_we_o,
  input logic                alert_o
);

  // Only reset clears an alert
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o)
    else $error("alert_o dropped without reset");

  sparse_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_we_o inside {aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::SP2V_LOW}) &&
    (in_ready_o inside {aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::SP2V_LOW}) &&
    (out_valid_o inside {aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::SP2V_LOW}))
    else $error("Invalid sparse code on a control output");

  // A fault may drop the result
  out_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni || alert_o)
    (out_valid_o == aes_ctrl_pkg::SP2V_HIGH) && (out_ready_i != aes_ctrl_pkg::SP2V_HIGH)
    |=> out_valid_o == aes_ctrl_pkg::SP2V_HIGH)
    else $error("out_valid_o dropped before the result was taken");

  ready_valid_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((in_ready_o == aes_ctrl_pkg::SP2V_HIGH) && (out_valid_o == aes_ctrl_pkg::SP2V_HIGH)))
    else $error("in_ready_o and out_valid_o high together");

endmodule

bind aes_cipher_ctrl aes_cipher_ctrl_sva aes_cipher_ctrl_sva_i (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .in_ready_o  ( in_ready_o  ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .state_we_o  ( state_we_o  ),
  .alert_o     ( alert_o     )
);

`default_nettype wire

/* tb/aes_cipher_ctrl_tb.sv */
// Random testbench for the AES cipher control unit, checked against a cycle model
`default_nettype none
`timescale 1ns/1ps

module aes_cipher_ctrl_tb;

  typedef enum logic [2:0] {M_IDLE, M_RUN, M_DONE, M_CLEAR, M_ERR} model_state_e;

  localparam aes_ctrl_pkg::sp2v_e HI = aes_ctrl_pkg::SP2V_HIGH;
  localparam aes_ctrl_pkg::sp2v_e LO = aes_ctrl_pkg::SP2V_LOW;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  aes_ctrl_pkg::ciph_cfg_t cfg;
  aes_ctrl_pkg::sp2v_e     in_valid, in_ready, out_valid, out_ready, state_we;
  logic                    key_clear, op_err, alert_fatal, key_clear_q, alert;
  aes_ctrl_pkg::dp_ctrl_t  dp_ctrl, exp_dp;
  aes_ctrl_pkg::ciph_op_e  kx_op;

  // Cycle model
  model_state_e            m_st;
  logic [3:0]              m_rnd, m_nr;
  aes_ctrl_pkg::ciph_op_e  m_op;
  logic                    m_kc;
  logic                    fault_now;

  integer seed      = 28051;
  int     errors    = 0;
  int     n_pass    = 0;
  int     n_fail    = 0;
  string  test_name = "";

  always #4 clk_i = ~clk_i; // 8 ns period

  aes_cipher_ctrl aes_cipher_ctrl_i (
    .clk_i           ( clk_i       ),
    .rst_ni          ( rst_ni      ),
    .cfg_i           ( cfg         ),
    .in_valid_i      ( in_valid    ),
    .in_ready_o      ( in_ready    ),
    .out_valid_o     ( out_valid   ),
    .out_ready_i     ( out_ready   ),
    .key_clear_i     ( key_clear   ),
    .op_err_i        ( op_err      ),
    .alert_fatal_i   ( alert_fatal ),
    .state_we_o      ( state_we    ),
    .dp_ctrl_o       ( dp_ctrl     ),
    .key_expand_op_o ( kx_op       ),
    .key_clear_o     ( key_clear_q ),
    .alert_o         ( alert       )
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int rounds_for(input aes_ctrl_pkg::key_len_e kl);
    case (kl)
      aes_ctrl_pkg::AES_192: return 12;
      aes_ctrl_pkg::AES_256: return 14;
      default:               return 10;
    endcase
  endfunction

  // Only 01 and 10 are legal
  function automatic bit bad_code(input logic [1:0] v);
    return (v != 2'b01) && (v != 2'b10);
  endfunction

  assign fault_now = bad_code(in_valid) | bad_code(out_ready) | op_err | alert_fatal;

  always @(posedge clk_i or negedge rst_ni) begin : model_step
    if (!rst_ni) begin
      m_st  <= M_IDLE;
      m_rnd <= '0;
      m_nr  <= 4'd10;
      m_op  <= aes_ctrl_pkg::CIPH_FWD;
      m_kc  <= 1'b0;
    end else begin
      if (m_st == M_IDLE) begin
        m_kc <= key_clear & ~fault_now; // Flag lives through clear and one idle cycle
      end
      if (fault_now || m_st == M_ERR) begin
        m_st <= M_ERR;
      end else begin
        case (m_st)
          M_IDLE: begin
            if (key_clear) begin
              m_st <= M_CLEAR;
            end else if (in_valid == HI) begin
              m_st  <= M_RUN;
              m_rnd <= '0;
              m_nr  <= 4'(rounds_for(cfg.key_len));
              m_op  <= cfg.op;
            end
          end
          M_RUN: begin
            if (m_rnd == m_nr) begin
              m_st <= M_DONE;
            end else begin
              m_rnd <= m_rnd + 4'd1;
            end
          end
          M_DONE: begin
            if (out_ready == HI) begin
              m_st  <= M_IDLE;
              m_rnd <= '0;
            end
          end
          default: m_st <= M_IDLE;
        endcase
      end
    end
  end

  always_comb begin : model_dp
    exp_dp.round      = m_rnd;
    exp_dp.state_sel  = aes_ctrl_pkg::STATE_INIT;
    exp_dp.add_rk_sel = aes_ctrl_pkg::ADD_RK_INIT;
    if (m_st == M_DONE || (m_st == M_RUN && m_rnd == m_nr)) begin
      exp_dp.state_sel  = aes_ctrl_pkg::STATE_ROUND;
      exp_dp.add_rk_sel = aes_ctrl_pkg::ADD_RK_FINAL;
    end else if (m_st == M_RUN && m_rnd != '0) begin
      exp_dp.state_sel  = aes_ctrl_pkg::STATE_ROUND;
      exp_dp.add_rk_sel = aes_ctrl_pkg::ADD_RK_ROUND;
    end
  end

  task automatic compare_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : model_check
    if (rst_ni === 1'b1) begin
      compare_val("in_ready", (m_st == M_IDLE) ? HI : LO, in_ready);
      compare_val("out_valid", (m_st == M_DONE) ? HI : LO, out_valid);
      compare_val("state_we", (m_st == M_RUN) ? HI : LO, state_we);
      compare_val("alert", m_st == M_ERR, alert);
      compare_val("key_clear", m_kc, key_clear_q);
      compare_val("key_expand_op", m_op, kx_op);
      if (m_st != M_ERR) begin
        compare_val("dp_ctrl", exp_dp, dp_ctrl);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic reset_dut();
    @(posedge clk_i);
    rst_ni      <= 1'b0;
    in_valid    <= LO;
    out_ready   <= LO;
    key_clear   <= 1'b0;
    op_err      <= 1'b0;
    alert_fatal <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare_val("reset_in_ready", HI, in_ready);
    compare_val("reset_out_valid", LO, out_valid);
    compare_val("reset_state_we", LO, state_we);
    compare_val("reset_alert", 0, alert);
    compare_val("reset_key_clear", 0, key_clear_q);
  endtask

  task automatic run_job();
    aes_ctrl_pkg::ciph_cfg_t job;
    aes_ctrl_pkg::dp_ctrl_t  held;
    int                      we_cnt;
    int                      cyc;
    int                      delay;
    job.key_len = aes_ctrl_pkg::key_len_e'($unsigned($random(seed)) % 3);
    job.op      = aes_ctrl_pkg::ciph_op_e'($random(seed) & 1);
    delay       = $unsigned($random(seed)) % 21;
    we_cnt      = 0;
    cyc         = 0;
    @(posedge clk_i);
    cfg      <= job;
    in_valid <= HI;
    @(posedge clk_i); // Accept edge
    in_valid <= LO;
    while (out_valid != HI && cyc < 40) begin
      @(negedge clk_i);
      if (state_we == HI) begin
        we_cnt++;
      end
      cyc++;
    end
    if (out_valid != HI) begin
      errors++;
      $display("%s: no result came out within 40 cycles", test_name);
      return;
    end
    compare_val("we_cycles", rounds_for(job.key_len) + 1, we_cnt);
    compare_val("accepted_op", job.op, kx_op);
    held = dp_ctrl;
    repeat (delay) begin // Back-pressure
      @(negedge clk_i);
      compare_val("held_dp_ctrl", held, dp_ctrl);
      compare_val("held_out_valid", HI, out_valid);
    end
    @(posedge clk_i);
    out_ready <= HI;
    @(posedge clk_i); // Take edge
    out_ready <= LO;
    @(negedge clk_i);
    compare_val("ready_after_take", HI, in_ready);
  endtask

  task automatic clear_key();
    int kc_cycles;
    int busy_cycles;
    kc_cycles   = 0;
    busy_cycles = 0;
    @(posedge clk_i);
    key_clear <= 1'b1;
    in_valid  <= HI;  // Has to lose against the clear
    @(posedge clk_i);
    key_clear <= 1'b0;
    in_valid  <= LO;
    repeat (3) begin
      @(negedge clk_i);
      kc_cycles += key_clear_q;
      busy_cycles += (in_ready != HI);
    end
    compare_val("key_clear_cycles", 2, kc_cycles);
    compare_val("clear_busy_cycles", 1, busy_cycles);
  endtask

  task automatic inject_fault(input int src);
    aes_ctrl_pkg::ciph_cfg_t job;
    int wait_cyc;
    int alert_low;
    int hs_high;
    job.key_len = aes_ctrl_pkg::key_len_e'($unsigned($random(seed)) % 3);
    job.op      = aes_ctrl_pkg::ciph_op_e'($random(seed) & 1);
    wait_cyc    = $unsigned($random(seed)) % 16;
    alert_low   = 0;
    hs_high     = 0;
    reset_dut();
    @(posedge clk_i);
    cfg      <= job;
    in_valid <= HI;
    @(posedge clk_i);
    in_valid <= LO;
    repeat (wait_cyc) @(posedge clk_i);
    case (src)
      0:       in_valid <= aes_ctrl_pkg::sp2v_e'(2'b00);
      1:       in_valid <= aes_ctrl_pkg::sp2v_e'(2'b11);
      2:       out_ready <= aes_ctrl_pkg::sp2v_e'(2'b00);
      3:       out_ready <= aes_ctrl_pkg::sp2v_e'(2'b11);
      4:       op_err <= 1'b1;
      default: alert_fatal <= 1'b1;
    endcase
    @(posedge clk_i);
    in_valid    <= LO;
    out_ready   <= LO;
    op_err      <= 1'b0;
    alert_fatal <= 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      alert_low += !alert;
      hs_high += (in_ready == HI) || (out_valid == HI);
    end
    compare_val("alert_low_cycles", 0, alert_low);
    compare_val("handshake_high_cycles", 0, hs_high);
  endtask

  task automatic end_test(input int err_start);
    if (errors == err_start) begin
      n_pass++;
      $display("%s: passed", test_name);
    end else begin
      n_fail++;
      $display("%s: failed with %0d errors", test_name, errors - err_start);
    end
  endtask

  initial begin : main
    int err_start;
    rst_ni      = 1'b0;
    cfg         = '0;
    in_valid    = LO;
    out_ready   = LO;
    key_clear   = 1'b0;
    op_err      = 1'b0;
    alert_fatal = 1'b0;

    test_name = "reset_state";
    err_start = errors;
    reset_dut();
    end_test(err_start);

    for (int i = 0; i < 12; i++) begin
      // First pass always runs a key clear
      if (i == 0 || $unsigned($random(seed)) % 4 == 0) begin
        test_name = $sformatf("key_clear_%0d", i);
        err_start = errors;
        clear_key();
        run_job();
        end_test(err_start);
      end
      test_name = $sformatf("job_%0d", i);
      err_start = errors;
      run_job();
      end_test(err_start);
    end

    // One reset interval per fault source
    for (int s = 0; s < 6; s++) begin
      test_name = $sformatf("fault_%0d", s);
      err_start = errors;
      inject_fault(s);
      end_test(err_start);
    end

    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
